//--- logic/scale_pkg.sv
// Shared widths and bundled types for the 1-D nearest-neighbour line scaler
// Configuration word loaded at start and the per-pixel output beat
package scale_pkg;

  // Output-pixel count and index width
  localparam int M_WIDTH_BITS = 12;

  // Source-pixel count and index width
  localparam int S_WIDTH_BITS = 10;

  // Source address width seen by the downstream DMA
  localparam int ADDR_BITS = 32;

  // Phase accumulator width
  // Holds m_width * (s_width + 1) and s_width * (m_width + 1) without wrap
  localparam int CNT_BITS = M_WIDTH_BITS + S_WIDTH_BITS + 1;

  // Line configuration, sampled only in the start cycle
  typedef struct packed {
    // Number of output pixels, never zero
    logic [M_WIDTH_BITS-1:0] m_width;
    // Number of source pixels, never zero
    logic [S_WIDTH_BITS-1:0] s_width;
    // Start of the source line buffer
    logic [ADDR_BITS-1:0]    s_base_addr;
    // Offset of the first sampled pixel inside the buffer
    logic [ADDR_BITS-1:0]    s_off_addr;
    // Address distance between neighbouring source pixels
    logic [ADDR_BITS-1:0]    s_inc_addr;
  } scale_cfg_t;

  // One output beat, one per output pixel
  typedef struct packed {
    // Address of the source pixel to sample
    logic [ADDR_BITS-1:0]    s_addr;
    // Index of that source pixel within the line
    logic [S_WIDTH_BITS-1:0] s_idx;
    // Index of the output pixel
    logic [M_WIDTH_BITS-1:0] m_idx;
    // Final beat of the line
    logic                    last;
  } scale_beat_t;

endpackage

//--- logic/scale_ctrl.sv
// Line controller for the scaler
// Run and last flags, output index, valid/ready handshake and DDA step strobes
module scale_ctrl (
  input  logic                              clk,
  input  logic                              i_arst_n,
  input  logic                              i_start,
  input  logic [scale_pkg::M_WIDTH_BITS-1:0] i_m_width,
  input  logic                              i_ready,
  input  logic                              i_ge,
  input  logic                              i_le,
  output logic                              o_valid,
  output logic                              o_busy,
  output logic                              o_step_m,
  output logic                              o_step_s,
  output logic [scale_pkg::M_WIDTH_BITS-1:0] o_m_idx,
  output logic                              o_last
);

  logic                              running;
  logic                              last;
  logic                              progress;
  logic                              final_xfer;
  logic                              penult_xfer;
  logic [scale_pkg::M_WIDTH_BITS-1:0] m_width_q;
  logic [scale_pkg::M_WIDTH_BITS-1:0] m_idx;

  // A beat is ready once the source phase has caught up with the output phase
  assign o_valid = running && i_ge;

  // Pipeline may move unless a beat is stuck waiting on downstream
  assign progress = !o_valid || i_ready;

  // Output side steps on every transfer
  assign o_step_m = o_valid && i_ready;

  // Source side steps while its phase trails or equals the output phase
  assign o_step_s = running && progress && i_le;

  // Transfer of the last and the next to last beat of the line
  // For m_width of 1 the penultimate compare wraps and never matches
  assign final_xfer  = o_step_m && (m_idx == m_width_q - scale_pkg::M_WIDTH_BITS'(1));
  assign penult_xfer = o_step_m && (m_idx == m_width_q - scale_pkg::M_WIDTH_BITS'(2));

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      running   <= 1'b0;
      last      <= 1'b0;
      m_idx     <= '0;
      m_width_q <= '0;
    end else if (i_start) begin
      // Start wins over any step, also mid-line
      running   <= 1'b1;
      last      <= 1'b0;
      m_idx     <= '0;
      m_width_q <= i_m_width;
    end else begin
      if (o_step_m) begin
        m_idx <= m_idx + scale_pkg::M_WIDTH_BITS'(1);
      end
      // Line ends with the final transfer
      if (final_xfer) begin
        running <= 1'b0;
      end
      // Flag the upcoming beat as the final one
      if (penult_xfer) begin
        last <= 1'b1;
      end
    end
  end

  assign o_busy  = running;
  assign o_m_idx = m_idx;
  assign o_last  = last;

  // Zero output width would never produce a beat
  a_start_m_width: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_start |-> (i_m_width != '0));

  // Under stall the beat stays offered and nothing in the line moves
  a_stall_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_valid && !i_ready && !i_start |=> o_valid && $stable({running, last, m_idx}));

  // Running only comes up from a start
  a_run_rise: assert property (@(posedge clk) disable iff (!i_arst_n)
    $rose(running) |-> $past(i_start));

  // Running only drops after the final transfer
  a_run_fall: assert property (@(posedge clk) disable iff (!i_arst_n)
    $fell(running) |-> $past(final_xfer));

  // Last holds until the next line is started
  a_last_sticky: assert property (@(posedge clk) disable iff (!i_arst_n)
    last && !i_start |=> last);

  // Index reaches m_width only after the final transfer
  a_m_idx_bound: assert property (@(posedge clk) disable iff (!i_arst_n)
    m_idx <= m_width_q);

endmodule

//--- logic/scale_dda.sv
// Cross-multiplied phase accumulators of the scaler
// Source phase steps by m_width, output phase by s_width
module scale_dda (
  input  logic                              clk,
  input  logic                              i_arst_n,
  input  logic                              i_start,
  input  logic [scale_pkg::M_WIDTH_BITS-1:0] i_m_width,
  input  logic [scale_pkg::S_WIDTH_BITS-1:0] i_s_width,
  input  logic                              i_step_m,
  input  logic                              i_step_s,
  output logic                              o_ge,
  output logic                              o_le
);

  // Step sizes widened to accumulator width
  logic [scale_pkg::CNT_BITS-1:0] s_step;
  logic [scale_pkg::CNT_BITS-1:0] m_step;

  // Source phase and output phase
  logic [scale_pkg::CNT_BITS-1:0] s_cnt;
  logic [scale_pkg::CNT_BITS-1:0] m_cnt;

  // Step sizes of the current line latched at start
  always_ff @(posedge clk) begin
    if (i_start) begin
      s_step <= scale_pkg::CNT_BITS'(i_m_width);
      m_step <= scale_pkg::CNT_BITS'(i_s_width);
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      s_cnt <= '0;
      m_cnt <= '0;
    end else if (i_start) begin
      // First step of each side is already taken
      s_cnt <= scale_pkg::CNT_BITS'(i_m_width);
      m_cnt <= scale_pkg::CNT_BITS'(i_s_width);
    end else begin
      // Both sides move together when the phases are equal
      if (i_step_s) begin
        s_cnt <= s_cnt + s_step;
      end
      if (i_step_m) begin
        m_cnt <= m_cnt + m_step;
      end
    end
  end

  // Source pixel covers the current output position
  assign o_ge = (s_cnt >= m_cnt);

  // Next source pixel is needed before the output can move on
  assign o_le = (s_cnt <= m_cnt);

  // Zero source width would stall the source side forever
  a_start_s_width: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_start |-> (i_s_width != '0));

  a_s_step: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_step_s && !i_start |=> s_cnt == $past(s_cnt) + s_step);

  a_m_step: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_step_m && !i_start |=> m_cnt == $past(m_cnt) + m_step);

  // Phases only move on their own strobes
  a_s_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
    !i_step_s && !i_start |=> $stable(s_cnt));

  a_m_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
    !i_step_m && !i_start |=> $stable(m_cnt));

endmodule

//--- logic/scale_src_addr.sv
// Source pixel index and address generator
// Steps in lockstep with the source phase of the DDA
module scale_src_addr (
  input  logic                              clk,
  input  logic                              i_arst_n,
  input  logic                              i_start,
  input  scale_pkg::scale_cfg_t             i_cfg,
  input  logic                              i_step_s,
  output logic [scale_pkg::S_WIDTH_BITS-1:0] o_s_idx,
  output logic [scale_pkg::ADDR_BITS-1:0]    o_s_addr
);

  logic [scale_pkg::S_WIDTH_BITS-1:0] s_idx;
  logic [scale_pkg::S_WIDTH_BITS-1:0] s_width_q;
  logic [scale_pkg::ADDR_BITS-1:0]    s_addr;
  logic [scale_pkg::ADDR_BITS-1:0]    s_inc_q;

  // Pixel pitch of the current line
  always_ff @(posedge clk) begin
    if (i_start) begin
      s_inc_q <= i_cfg.s_inc_addr;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      s_idx     <= '0;
      s_addr    <= '0;
      s_width_q <= '0;
    end else if (i_start) begin
      // First sampled pixel sits at base plus offset
      s_idx     <= '0;
      s_addr    <= i_cfg.s_base_addr + i_cfg.s_off_addr;
      s_width_q <= i_cfg.s_width;
    end else if (i_step_s) begin
      s_idx  <= s_idx + scale_pkg::S_WIDTH_BITS'(1);
      s_addr <= s_addr + s_inc_q;
    end
  end

  assign o_s_idx  = s_idx;
  assign o_s_addr = s_addr;

  // Index and address advance together by exactly one pixel
  a_step_pair: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_step_s && !i_start |=>
      (s_idx == $past(s_idx) + scale_pkg::S_WIDTH_BITS'(1)) &&
      (s_addr == $past(s_addr) + s_inc_q));

  // Neither moves without a source step
  a_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
    !i_step_s && !i_start |=> $stable({s_idx, s_addr}));

  // Final transfer may push the index one past the last source pixel
  a_s_idx_bound: assert property (@(posedge clk) disable iff (!i_arst_n)
    s_idx <= s_width_q);

endmodule

//--- logic/scale_top.sv
// Top level of the 1-D nearest-neighbour line scaler
// Controller, phase accumulators and address generator feeding one beat stream
module scale_top (
  input  logic                   clk,
  input  logic                   i_arst_n,
  input  logic                   i_start,
  input  scale_pkg::scale_cfg_t  i_cfg,
  input  logic                   i_ready,
  output logic                   o_valid,
  output logic                   o_busy,
  output scale_pkg::scale_beat_t o_beat
);

  // Phase comparison from the DDA
  logic ge;
  logic le;

  // Step strobes from the controller
  logic step_m;
  logic step_s;

  // Beat fields
  logic [scale_pkg::M_WIDTH_BITS-1:0] m_idx;
  logic                              last;
  logic [scale_pkg::S_WIDTH_BITS-1:0] s_idx;
  logic [scale_pkg::ADDR_BITS-1:0]    s_addr;

  scale_ctrl u_ctrl (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_start  (i_start),
    .i_m_width(i_cfg.m_width),
    .i_ready  (i_ready),
    .i_ge     (ge),
    .i_le     (le),
    .o_valid  (o_valid),
    .o_busy   (o_busy),
    .o_step_m (step_m),
    .o_step_s (step_s),
    .o_m_idx  (m_idx),
    .o_last   (last)
  );

  scale_dda u_dda (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_start  (i_start),
    .i_m_width(i_cfg.m_width),
    .i_s_width(i_cfg.s_width),
    .i_step_m (step_m),
    .i_step_s (step_s),
    .o_ge     (ge),
    .o_le     (le)
  );

  scale_src_addr u_src_addr (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_start  (i_start),
    .i_cfg    (i_cfg),
    .i_step_s (step_s),
    .o_s_idx  (s_idx),
    .o_s_addr (s_addr)
  );

  // Source fields from the address generator, output fields from the controller
  assign o_beat = '{s_addr: s_addr, s_idx: s_idx, m_idx: m_idx, last: last};

endmodule

//--- testbench/scale_tb.sv
// Testbench for the 1-D line scaler
// Directed and random lines checked beat by beat against a reference model
module scale_tb;

  logic                   clk;
  logic                   i_arst_n;
  logic                   i_start;
  scale_pkg::scale_cfg_t  i_cfg;
  logic                   i_ready;
  logic                   o_valid;
  logic                   o_busy;
  scale_pkg::scale_beat_t o_beat;

  integer seed;
  string  test_name;
  int     value_errors;
  int     protocol_errors;
  int     timeouts;
  bit     stopped;

  // Monitor state
  scale_pkg::scale_cfg_t  line_cfg;
  scale_pkg::scale_beat_t held_beat;
  scale_pkg::scale_beat_t exp_beat;
  int                     beat_cnt;
  bit                     chk_busy;
  bit                     chk_end;
  bit                     chk_stall;

  scale_top dut0 (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_start  (i_start),
    .i_cfg    (i_cfg),
    .i_ready  (i_ready),
    .o_valid  (o_valid),
    .o_busy   (o_busy),
    .o_beat   (o_beat)
  );

  always #50 clk = ~clk;

  // Expected beat for output pixel k
  function automatic scale_pkg::scale_beat_t ref_beat(input scale_pkg::scale_cfg_t cfg,
                                                      input int k);
    scale_pkg::scale_beat_t beat;
    int num;
    int idx;
    // Right edge of output pixel k in source units times m_width
    num = (k + 1) * int'(cfg.s_width);
    // First source pixel whose right edge reaches it
    idx = (num + int'(cfg.m_width) - 1) / int'(cfg.m_width) - 1;
    beat.s_idx  = scale_pkg::S_WIDTH_BITS'(idx);
    beat.s_addr = cfg.s_base_addr + cfg.s_off_addr +
                  scale_pkg::ADDR_BITS'(idx) * cfg.s_inc_addr;
    beat.m_idx  = scale_pkg::M_WIDTH_BITS'(k);
    beat.last   = (cfg.m_width >= 2) && (k == int'(cfg.m_width) - 1);
    return beat;
  endfunction

  // Comparing process, samples at the rising edge where inputs are settled
  always @(posedge clk) begin
    if (i_arst_n) begin
      // Line must be running right after a start
      if (chk_busy && !o_busy) begin
        protocol_errors++;
        $display("ERROR %s: o_busy after start expected 1 actual 0", test_name);
      end
      // Line winds down one cycle after its final transfer
      if (chk_end && (o_busy || o_valid)) begin
        protocol_errors++;
        $display("ERROR %s: busy/valid after final beat expected 0/0 actual %0d/%0d",
                 test_name, o_busy, o_valid);
      end
      // Offered beat holds under back-pressure
      if (chk_stall && (!o_valid || o_beat != held_beat)) begin
        protocol_errors++;
        $display("ERROR %s: stalled beat expected %h actual %h (valid %0d)",
                 test_name, held_beat, o_beat, o_valid);
      end
      chk_busy  = 1'b0;
      chk_end   = 1'b0;
      chk_stall = 1'b0;
      if (i_start) begin
        // New line, earlier beats are forgotten
        line_cfg = i_cfg;
        beat_cnt = 0;
        chk_busy = 1'b1;
      end else if (o_valid && i_ready) begin
        if (beat_cnt >= int'(line_cfg.m_width)) begin
          protocol_errors++;
          $display("ERROR %s: extra beat after %0d beats of the line", test_name, beat_cnt);
        end else begin
          exp_beat = ref_beat(line_cfg, beat_cnt);
          if (o_beat.s_idx != exp_beat.s_idx) begin
            value_errors++;
            $display("ERROR %s: s_idx of beat %0d expected %0d actual %0d",
                     test_name, beat_cnt, exp_beat.s_idx, o_beat.s_idx);
          end
          if (o_beat.s_addr != exp_beat.s_addr) begin
            value_errors++;
            $display("ERROR %s: s_addr of beat %0d expected %h actual %h",
                     test_name, beat_cnt, exp_beat.s_addr, o_beat.s_addr);
          end
          if (o_beat.m_idx != exp_beat.m_idx) begin
            value_errors++;
            $display("ERROR %s: m_idx of beat %0d expected %0d actual %0d",
                     test_name, beat_cnt, exp_beat.m_idx, o_beat.m_idx);
          end
          if (o_beat.last != exp_beat.last) begin
            value_errors++;
            $display("ERROR %s: last of beat %0d expected %0d actual %0d",
                     test_name, beat_cnt, exp_beat.last, o_beat.last);
          end
          beat_cnt++;
          if (beat_cnt == int'(line_cfg.m_width)) begin
            chk_end = 1'b1;
          end
        end
      end else if (o_valid && !i_ready) begin
        chk_stall = 1'b1;
        held_beat = o_beat;
      end
    end
  end

  // Downstream ready, always or mostly high
  task automatic drive_ready(input bit random_ready);
    if (random_ready) begin
      i_ready = (($random(seed) & 7) != 0);
    end else begin
      i_ready = 1'b1;
    end
  endtask

  // One-cycle start strobe, ready low so no beat moves in the start cycle
  task automatic start_line(input scale_pkg::scale_cfg_t cfg);
    if (stopped) return;
    @(negedge clk);
    i_cfg   = cfg;
    i_start = 1'b1;
    i_ready = 1'b0;
    @(negedge clk);
    i_start = 1'b0;
    // Config is only sampled at start, scramble it afterwards
    i_cfg   = ~cfg;
  endtask

  // Run until the line ends, then check the beat count
  task automatic finish_line(input scale_pkg::scale_cfg_t cfg, input bit random_ready);
    int cyc;
    int limit;
    if (stopped) return;
    limit = int'(cfg.m_width) + int'(cfg.s_width) + 50;
    cyc   = 0;
    while (o_busy && cyc < limit) begin
      drive_ready(random_ready);
      @(negedge clk);
      cyc++;
    end
    if (o_busy) begin
      timeouts++;
      stopped = 1'b1;
      $display("Line of %0d output and %0d source pixels never finished within %0d cycles",
               cfg.m_width, cfg.s_width, limit);
    end else if (beat_cnt != int'(cfg.m_width)) begin
      protocol_errors++;
      $display("ERROR %s: beat count expected %0d actual %0d",
               test_name, cfg.m_width, beat_cnt);
    end
  endtask

  // Run until n beats of the current line have transferred
  task automatic wait_beats(input scale_pkg::scale_cfg_t cfg, input int n);
    int cyc;
    int limit;
    if (stopped) return;
    limit = int'(cfg.m_width) + int'(cfg.s_width) + 50;
    cyc   = 0;
    while (beat_cnt < n && cyc < limit) begin
      drive_ready(1'b1);
      @(negedge clk);
      cyc++;
    end
    if (beat_cnt < n) begin
      timeouts++;
      stopped = 1'b1;
      $display("Line never reached %0d beats within %0d cycles", n, limit);
    end
  endtask

  // Directed line with fixed addressing
  task automatic run_line(input string name, input int m, input int s, input bit random_ready);
    scale_pkg::scale_cfg_t cfg;
    test_name        = name;
    cfg.m_width      = scale_pkg::M_WIDTH_BITS'(m);
    cfg.s_width      = scale_pkg::S_WIDTH_BITS'(s);
    cfg.s_base_addr  = 32'h1000_0000;
    cfg.s_off_addr   = 32'h0000_0040;
    cfg.s_inc_addr   = 32'd4;
    start_line(cfg);
    finish_line(cfg, random_ready);
  endtask

  // Random widths up to 64 and non-zero offset and increment
  task automatic make_cfg(output scale_pkg::scale_cfg_t cfg);
    cfg.m_width     = scale_pkg::M_WIDTH_BITS'(1 + ($random(seed) & 63));
    cfg.s_width     = scale_pkg::S_WIDTH_BITS'(1 + ($random(seed) & 63));
    cfg.s_base_addr = $random(seed);
    cfg.s_off_addr  = ($random(seed) & 32'h0000_ffff) | 32'd1;
    cfg.s_inc_addr  = 32'd1 + ($random(seed) & 15);
  endtask

  initial begin
    scale_pkg::scale_cfg_t cfg;
    int i;
    seed            = 41678;
    clk             = 1'b0;
    i_arst_n        = 1'b0;
    i_start         = 1'b0;
    i_cfg           = '0;
    i_ready         = 1'b0;
    value_errors    = 0;
    protocol_errors = 0;
    timeouts        = 0;
    stopped         = 1'b0;
    line_cfg        = '0;
    held_beat       = '0;
    exp_beat        = '0;
    beat_cnt        = 0;
    chk_busy        = 1'b0;
    chk_end         = 1'b0;
    chk_stall       = 1'b0;

    // Idle through reset and until the first start
    test_name = "reset";
    for (i = 0; i < 13; i++) begin
      @(negedge clk);
      if (i == 10) begin
        i_arst_n = 1'b1;
      end
      if (o_valid || o_busy) begin
        protocol_errors++;
        $display("ERROR %s: valid/busy expected 0/0 actual %0d/%0d",
                 test_name, o_valid, o_busy);
      end
    end

    // Ready held high
    run_line("equal", 16, 16, 1'b0);
    run_line("upscale", 20, 7, 1'b0);
    run_line("downscale", 7, 20, 1'b0);

    // Random back-pressure
    run_line("equal_bp", 16, 16, 1'b1);
    run_line("upscale_bp", 20, 7, 1'b1);
    run_line("downscale_bp", 7, 20, 1'b1);

    // Edge widths
    run_line("edge_m1_s1", 1, 1, 1'b0);
    run_line("edge_m1_s5", 1, 5, 1'b1);
    run_line("edge_m2_s1", 2, 1, 1'b0);
    run_line("edge_m2_s9", 2, 9, 1'b1);
    run_line("edge_m9_s1", 9, 1, 1'b1);

    // Back to back random lines, one of them cut short by the next start
    test_name = "random";
    for (i = 0; i < 20; i++) begin
      make_cfg(cfg);
      if (i == 10) begin
        cfg.m_width = cfg.m_width + scale_pkg::M_WIDTH_BITS'(8);
        start_line(cfg);
        wait_beats(cfg, 4);
      end else begin
        start_line(cfg);
        finish_line(cfg, 1'b1);
      end
    end

    repeat (3) @(negedge clk);
    $display("Value errors: %0d, protocol errors: %0d, timeouts: %0d",
             value_errors, protocol_errors, timeouts);
    if (value_errors + protocol_errors + timeouts == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
logic/scale_pkg.sv
logic/scale_ctrl.sv
logic/scale_dda.sv
logic/scale_src_addr.sv
logic/scale_top.sv
testbench/scale_tb.sv

//--- Bender.yml
package:
  name: scale_line

sources:
  # Design, package first
  - logic/scale_pkg.sv
  - logic/scale_ctrl.sv
  - logic/scale_dda.sv
  - logic/scale_src_addr.sv
  - logic/scale_top.sv

  # Simulation only
  - target: test
    files:
      - testbench/scale_tb.sv
